//--- source/rng_defs.svh
`ifndef RNG_DEFS_SVH
`define RNG_DEFS_SVH

// words held between generator and register slave
`define RNG_FIFO_DEPTH 16

// register map, byte addresses on the axi4-lite port
`define RNG_ADDR_CTRL   32'h0000_0000 // bit0 enable, bit1 commit seed
`define RNG_ADDR_STATUS 32'h0000_0004 // fifo level, empty, full
`define RNG_ADDR_DATA   32'h0000_0008 // read pops one word
`define RNG_ADDR_SEED0  32'h0000_0010
`define RNG_ADDR_SEED1  32'h0000_0014
`define RNG_ADDR_SEED2  32'h0000_0018
`define RNG_ADDR_SEED3  32'h0000_001C

// generator state after reset
// any value except all zero works, xoshiro locks up on zero
`define RNG_DEFAULT_SEED0 32'h1234_5678
`define RNG_DEFAULT_SEED1 32'h9ABC_DEF0
`define RNG_DEFAULT_SEED2 32'h0FED_CBA9
`define RNG_DEFAULT_SEED3 32'h8765_4321

// status word layout on a STATUS read
// [6:2] level
// [1]   empty
// [0]   full

`endif

//--- source/rng_pkg.sv
package rng_pkg;

  // one generator result
  typedef logic [31:0] rng_word_t;

  // fifo fill level, wide enough for a full 16 deep buffer
  typedef logic [4:0] rng_level_t;

  // generator state, also used for the staged seed
  typedef struct packed {
    rng_word_t s0;
    rng_word_t s1;
    rng_word_t s2;
    rng_word_t s3;
  } rng_seed_t;

  typedef struct packed {
    rng_level_t level; // words currently buffered
    logic       empty;
    logic       full;
  } rng_status_t;

  // axi4-lite response codes
  typedef enum logic [1:0] {
    AXIL_OKAY   = 2'b00,
    AXIL_SLVERR = 2'b10
  } axil_resp_t;

  typedef struct packed {
    logic [31:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [31:0] data; // full word writes only
  } axil_w_t;

  typedef struct packed {
    logic [31:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [31:0] data;
    axil_resp_t  resp;
  } axil_r_t;

endpackage

//--- source/prng_xoshiro128pp.sv
`timescale 1ns/1ns

`include "rng_defs.svh"

// xoshiro128++ generator with a registered result and valid/ready output
module prng_xoshiro128pp (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_seed_load, // one cycle, wins over generation
  input  rng_pkg::rng_seed_t i_seed,
  output logic               o_valid,
  input  logic               i_ready,     // enable and room downstream
  output rng_pkg::rng_word_t o_word,
  output rng_pkg::rng_seed_t o_state      // live state for readback
);
  import rng_pkg::*;

  localparam int ROT_RES = 7;  // result rotate
  localparam int SHL_T   = 9;  // t = s1 << 9
  localparam int ROT_S3  = 11; // final s3 rotate

  rng_seed_t state_q;
  rng_seed_t state_nxt;
  rng_word_t word_q;
  rng_word_t word_nxt;
  rng_word_t sum03;
  rng_word_t t_shl;
  rng_word_t s0_x;
  rng_word_t s1_x;
  rng_word_t s2_x;
  rng_word_t s3_x;
  logic      valid_q;

  function automatic rng_word_t rotl(input rng_word_t x, input int k);
    return (x << k) | (x >> (32 - k));
  endfunction

  // result = rotl(s0 + s3, 7) + s0
  always_comb begin
    sum03    = state_q.s0 + state_q.s3;
    word_nxt = rotl(sum03, ROT_RES) + state_q.s0;
  end

  // next state, each xor sees the words already updated above it
  always_comb begin
    t_shl = state_q.s1 << SHL_T;
    s2_x  = state_q.s2 ^ state_q.s0; // s2 ^= s0
    s3_x  = state_q.s3 ^ state_q.s1; // s3 ^= s1
    s1_x  = state_q.s1 ^ s2_x;       // s1 ^= s2 (new)
    s0_x  = state_q.s0 ^ s3_x;       // s0 ^= s3 (new)
    state_nxt.s0 = s0_x;
    state_nxt.s1 = s1_x;
    state_nxt.s2 = s2_x ^ t_shl;
    state_nxt.s3 = rotl(s3_x, ROT_S3);
  end

  // state and valid flag
  // output register fills whenever ready, a held word means state is one step ahead
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= '{`RNG_DEFAULT_SEED0, `RNG_DEFAULT_SEED1,
                   `RNG_DEFAULT_SEED2, `RNG_DEFAULT_SEED3};
      valid_q <= 1'b0;
    end else if (i_seed_load) begin
      state_q <= i_seed;
      valid_q <= 1'b0; // old word is dropped with the flush
    end else if (i_ready) begin
      state_q <= state_nxt; // advance with each new result
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_seed_load && i_ready) begin
      word_q <= word_nxt;
    end
  end

  assign o_valid = valid_q;
  assign o_word  = word_q;
  assign o_state = state_q;

endmodule

//--- source/sync_fifo.sv
`timescale 1ns/1ns

// single clock circular buffer for generator words
module sync_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_flush, // empties in one cycle
  input  logic                 i_push,
  input  rng_pkg::rng_word_t   i_data,
  output logic                 o_full,
  input  logic                 i_pop,
  output rng_pkg::rng_word_t   o_data,  // head word, valid when not empty
  output rng_pkg::rng_status_t o_status
);
  import rng_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  rng_word_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  rng_level_t       count;
  logic             do_push;
  logic             do_pop;

  // wrap explicitly so non power of two depths work
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_push = i_push && !o_full;     // push on full is dropped
  assign do_pop  = i_pop && (count != '0); // pop on empty is dropped

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst || i_flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  assign o_full = (count == rng_level_t'(DEPTH));
  assign o_data = mem[rd_ptr]; // push shows at head one cycle later

  always_comb begin
    o_status.level = count;
    o_status.empty = (count == '0);
    o_status.full  = o_full;
  end

endmodule

//--- source/axil_rng_regs.sv
`timescale 1ns/1ns

`include "rng_defs.svh"

// axi4-lite register slave for the rng service
// aw and w are taken in the same cycle, one outstanding write and one read
module axil_rng_regs (
  input  logic                 i_clk,
  input  logic                 i_rst,
  // write address and data
  input  logic                 i_awvalid,
  output logic                 o_awready,
  input  rng_pkg::axil_aw_t    i_aw,
  input  logic                 i_wvalid,
  output logic                 o_wready,
  input  rng_pkg::axil_w_t     i_w,
  // write response
  output logic                 o_bvalid,
  input  logic                 i_bready,
  output rng_pkg::axil_resp_t  o_bresp,
  // read address and data
  input  logic                 i_arvalid,
  output logic                 o_arready,
  input  rng_pkg::axil_ar_t    i_ar,
  output logic                 o_rvalid,
  input  logic                 i_rready,
  output rng_pkg::axil_r_t     o_r,
  // generator side
  output logic                 o_enable,
  output logic                 o_seed_load, // commit pulse, also flushes fifo
  output rng_pkg::rng_seed_t   o_seed,
  input  rng_pkg::rng_seed_t   i_state,
  // fifo side
  input  rng_pkg::rng_status_t i_status,
  output logic                 o_pop,
  input  rng_pkg::rng_word_t   i_data
);
  import rng_pkg::*;

  logic        enable_q;
  logic        seed_load_q;
  rng_seed_t   seed_q;      // staged seed, applied on commit
  logic        bvalid_q;
  axil_resp_t  bresp_q;
  logic        rvalid_q;
  axil_r_t     r_q;
  axil_r_t     rd_resp;
  logic [31:0] wr_addr;
  logic [31:0] rd_addr;
  logic        wr_fire;
  logic        rd_fire;
  logic        rd_is_data;

  // word aligned decode, byte offset bits ignored
  assign wr_addr = {i_aw.addr[31:2], 2'b00};
  assign rd_addr = {i_ar.addr[31:2], 2'b00};

  assign o_awready = !bvalid_q; // blocked while b is pending
  assign o_wready  = !bvalid_q;
  assign wr_fire   = i_awvalid && i_wvalid && !bvalid_q;

  assign o_arready  = !rvalid_q;
  assign rd_fire    = i_arvalid && !rvalid_q;
  assign rd_is_data = (rd_addr == `RNG_ADDR_DATA);
  assign o_pop      = rd_fire && rd_is_data && !i_status.empty; // once per accepted read

  // write path
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      enable_q    <= 1'b0;
      seed_load_q <= 1'b0;
      seed_q      <= '{`RNG_DEFAULT_SEED0, `RNG_DEFAULT_SEED1,
                       `RNG_DEFAULT_SEED2, `RNG_DEFAULT_SEED3};
      bvalid_q    <= 1'b0;
      bresp_q     <= AXIL_OKAY;
    end else begin
      seed_load_q <= 1'b0; // pulse lasts one cycle
      if (bvalid_q && i_bready) bvalid_q <= 1'b0;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        bresp_q  <= AXIL_OKAY;
        case (wr_addr)
          `RNG_ADDR_CTRL: begin
            enable_q    <= i_w.data[0];
            seed_load_q <= i_w.data[1]; // commit staged seed
          end
          `RNG_ADDR_STATUS, `RNG_ADDR_DATA: begin
            // read only, write dropped with okay
          end
          `RNG_ADDR_SEED0: seed_q.s0 <= i_w.data;
          `RNG_ADDR_SEED1: seed_q.s1 <= i_w.data;
          `RNG_ADDR_SEED2: seed_q.s2 <= i_w.data;
          `RNG_ADDR_SEED3: seed_q.s3 <= i_w.data;
          default:         bresp_q <= AXIL_SLVERR; // unmapped
        endcase
      end
    end
  end

  // read mux, seed registers show the live generator state
  always_comb begin
    rd_resp.data = '0;
    rd_resp.resp = AXIL_OKAY;
    case (rd_addr)
      `RNG_ADDR_CTRL:   rd_resp.data = {31'b0, enable_q};
      `RNG_ADDR_STATUS: rd_resp.data = {{(32 - $bits(rng_status_t)){1'b0}}, i_status};
      `RNG_ADDR_DATA: begin
        if (i_status.empty) begin
          rd_resp.resp = AXIL_SLVERR; // nothing to pop, data stays zero
        end else begin
          rd_resp.data = i_data;
        end
      end
      `RNG_ADDR_SEED0:  rd_resp.data = i_state.s0;
      `RNG_ADDR_SEED1:  rd_resp.data = i_state.s1;
      `RNG_ADDR_SEED2:  rd_resp.data = i_state.s2;
      `RNG_ADDR_SEED3:  rd_resp.data = i_state.s3;
      default:          rd_resp.resp = AXIL_SLVERR;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (i_rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // response captured at acceptance, held until rready
  always_ff @(posedge i_clk) begin
    if (rd_fire) r_q <= rd_resp;
  end

  assign o_bvalid    = bvalid_q;
  assign o_bresp     = bresp_q;
  assign o_rvalid    = rvalid_q;
  assign o_r         = r_q;
  assign o_enable    = enable_q;
  assign o_seed_load = seed_load_q;
  assign o_seed      = seed_q;

endmodule

//--- source/rng_subsystem_top.sv
`timescale 1ns/1ns

`include "rng_defs.svh"

// random number service: generator -> fifo -> axi4-lite registers
module rng_subsystem_top (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_awvalid,
  output logic                o_awready,
  input  rng_pkg::axil_aw_t   i_aw,
  input  logic                i_wvalid,
  output logic                o_wready,
  input  rng_pkg::axil_w_t    i_w,
  output logic                o_bvalid,
  input  logic                i_bready,
  output rng_pkg::axil_resp_t o_bresp,
  input  logic                i_arvalid,
  output logic                o_arready,
  input  rng_pkg::axil_ar_t   i_ar,
  output logic                o_rvalid,
  input  logic                i_rready,
  output rng_pkg::axil_r_t    o_r
);
  import rng_pkg::*;

  logic        seed_load; // commit pulse, reloads state and flushes fifo
  rng_seed_t   seed;
  rng_seed_t   state;
  logic        enable;
  logic        gen_valid;
  logic        gen_ready;
  rng_word_t   gen_word;
  logic        fifo_full;
  logic        pop;
  rng_word_t   head;
  rng_status_t status;

  assign gen_ready = enable && !fifo_full; // producer runs only with room

  prng_xoshiro128pp prng_xoshiro128pp_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_seed_load (seed_load),
    .i_seed      (seed),
    .o_valid     (gen_valid),
    .i_ready     (gen_ready),
    .o_word      (gen_word),
    .o_state     (state)
  );

  sync_fifo #(
    .DEPTH (`RNG_FIFO_DEPTH)
  ) sync_fifo_inst (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_flush  (seed_load),
    .i_push   (gen_valid && gen_ready), // transfer
    .i_data   (gen_word),
    .o_full   (fifo_full),
    .i_pop    (pop),
    .o_data   (head),
    .o_status (status)
  );

  axil_rng_regs axil_rng_regs_inst (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_awvalid (i_awvalid), .o_awready (o_awready), .i_aw (i_aw),
    .i_wvalid (i_wvalid), .o_wready (o_wready), .i_w (i_w),
    .o_bvalid (o_bvalid), .i_bready (i_bready), .o_bresp (o_bresp),
    .i_arvalid (i_arvalid), .o_arready (o_arready), .i_ar (i_ar),
    .o_rvalid (o_rvalid), .i_rready (i_rready), .o_r (o_r),
    .o_enable (enable), .o_seed_load (seed_load), .o_seed (seed),
    .i_state (state), .i_status (status), .o_pop (pop), .i_data (head)
  );

endmodule

//--- test/tb_axil_bfm.svh
`ifndef TB_AXIL_BFM_SVH
`define TB_AXIL_BFM_SVH

// advance one clock and land 1 ns past the rising edge
task automatic step();
  @(posedge clk);
  #1;
endtask

// aw and w go out together and the slave takes both in one cycle
task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                         output axil_resp_t resp);
  aw.addr = addr;
  w.data  = data;
  awvalid = 1'b1;
  wvalid  = 1'b1;
  while (!(awready && wready)) step(); // ready only depends on registers
  step();
  awvalid = 1'b0;
  wvalid  = 1'b0;
  while (!bvalid) step();
  step(); // B waits one cycle with bready low
  resp   = bresp;
  bready = 1'b1;
  step();
  bready = 1'b0;
endtask

// hold > 0 keeps rready low that many cycles with R pending
task automatic read_reg(input logic [31:0] addr, input int hold, output axil_r_t rd);
  ar.addr = addr;
  arvalid = 1'b1;
  while (!arready) step();
  step();
  arvalid = 1'b0;
  while (!rvalid) step();
  repeat (hold) step();
  rd     = r_out;
  rready = 1'b1;
  step();
  rready = 1'b0;
endtask

// 32 bit xorshift with shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] rot_left(input logic [31:0] x, input int k);
  logic [63:0] d;
  d = {x, x} << k;
  return d[63:32]; // upper half holds the rotated word
endfunction

// reference xoshiro128++ next() that returns the result and advances s
task automatic model_step(inout rng_seed_t s, output rng_word_t res);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] c;
  logic [31:0] d;
  logic [31:0] t;
  a   = s.s0;
  b   = s.s1;
  c   = s.s2;
  d   = s.s3;
  res = rot_left(a + d, 7) + a;
  t   = b << 9;
  c   = c ^ a;
  d   = d ^ b;
  b   = b ^ c;
  a   = a ^ d;
  c   = c ^ t;
  d   = rot_left(d, 11);
  s   = '{a, b, c, d};
endtask

`endif

//--- test/tb_rng_subsystem.sv
`timescale 1ns/1ns

`include "rng_defs.svh"

module tb_rng_subsystem;
  import rng_pkg::*;

  localparam int CLK_NS      = 4;
  localparam int NUM_XFERS   = 400; // register accesses over all tests including polls
  localparam int XFER_CYCLES = 6;   // worst case per access
  localparam int WATCHDOG_NS = (NUM_XFERS * XFER_CYCLES + 500) * CLK_NS;
  localparam int POLL_LIMIT  = 64;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        awvalid, awready, wvalid, wready;
  logic        bvalid, bready, arvalid, arready, rvalid, rready;
  axil_aw_t    aw;
  axil_w_t     w;
  axil_resp_t  bresp;
  axil_ar_t    ar;
  axil_r_t     r_out;
  rng_seed_t   model;              // reference generator state
  logic [31:0] rnd = 32'd29258;    // xorshift state
  string       test_name = "none";
  int          checks = 0;
  int          errors = 0;

  rng_subsystem_top rng_subsystem_top_inst (
    .i_clk (clk), .i_rst (rst),
    .i_awvalid (awvalid), .o_awready (awready), .i_aw (aw),
    .i_wvalid (wvalid), .o_wready (wready), .i_w (w),
    .o_bvalid (bvalid), .i_bready (bready), .o_bresp (bresp),
    .i_arvalid (arvalid), .o_arready (arready), .i_ar (ar),
    .o_rvalid (rvalid), .i_rready (rready), .o_r (r_out)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // slave outputs must hold while the master stalls
  r_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(r_out))
    else begin
      errors++;
      $display("R channel changed or dropped while rready was low");
    end

  b_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      errors++;
      $display("B channel changed or dropped while bready was low");
    end

  // no new request is taken while its response is still pending
  busy_ready: assert property (@(posedge clk) disable iff (rst)
    !(bvalid && (awready || wready)) && !(rvalid && arready))
    else begin
      errors++;
      $display("request ready was high while a response was pending");
    end

  `include "tb_axil_bfm.svh"

  task automatic check_value(input string what, input logic [31:0] want, input logic [31:0] got);
    checks++;
    assert (got == want) else begin
      errors++;
      $display("Error %s: %s expected %08h actual %08h", test_name, what, want, got);
    end
  endtask

  // STATUS layout is level in [6:2] then empty and full
  function automatic logic [31:0] status_word(input int level, input logic empty,
                                              input logic full);
    return {25'd0, level[4:0], empty, full};
  endfunction

  function automatic rng_seed_t random_seed();
    rng_seed_t s;
    rnd  = xorshift32(rnd);
    s.s0 = rnd;
    rnd  = xorshift32(rnd);
    s.s1 = rnd;
    rnd  = xorshift32(rnd);
    s.s2 = rnd;
    rnd  = xorshift32(rnd);
    s.s3 = rnd;
    return s;
  endfunction

  task automatic load_seed(input rng_seed_t s);
    axil_resp_t resp;
    write_reg(`RNG_ADDR_SEED0, s.s0, resp);
    write_reg(`RNG_ADDR_SEED1, s.s1, resp);
    write_reg(`RNG_ADDR_SEED2, s.s2, resp);
    write_reg(`RNG_ADDR_SEED3, s.s3, resp);
    write_reg(`RNG_ADDR_CTRL, 32'h3, resp); // commit + enable
    check_value("CTRL bresp", 32'(AXIL_OKAY), 32'(resp));
    model = s;
  endtask

  task automatic check_seed_regs(input rng_seed_t want);
    axil_r_t rd;
    read_reg(`RNG_ADDR_SEED0, 0, rd);
    check_value("SEED0", want.s0, rd.data);
    read_reg(`RNG_ADDR_SEED1, 0, rd);
    check_value("SEED1", want.s1, rd.data);
    read_reg(`RNG_ADDR_SEED2, 0, rd);
    check_value("SEED2", want.s2, rd.data);
    read_reg(`RNG_ADDR_SEED3, 0, rd);
    check_value("SEED3", want.s3, rd.data);
  endtask

  task automatic wait_nonempty();
    axil_r_t rd;
    int      polls;
    polls = 0;
    do begin
      read_reg(`RNG_ADDR_STATUS, 0, rd);
      polls++;
    end while (rd.data[1] && polls < POLL_LIMIT);
    if (rd.data[1]) begin
      errors++;
      $display("%s: FIFO still empty after %0d STATUS reads", test_name, polls);
    end
  endtask

  // each DATA read must be the model's next word
  task automatic pop_and_check(input int n);
    axil_r_t   rd;
    rng_word_t want;
    for (int i = 0; i < n; i++) begin
      wait_nonempty();
      read_reg(`RNG_ADDR_DATA, 0, rd);
      model_step(model, want);
      check_value("DATA word", want, rd.data);
      check_value("DATA resp", 32'(AXIL_OKAY), 32'(rd.resp));
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, test sequence did not finish in time");
    $display("Test failed");
    $finish;
  end

  initial begin
    axil_r_t    rd;
    axil_resp_t resp;
    rng_seed_t  ahead;
    rng_word_t  skip;
    int         polls;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    bready  = 1'b0;
    rready  = 1'b0;
    aw      = '0;
    w       = '0;
    ar      = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    test_name = "reset";
    read_reg(`RNG_ADDR_STATUS, 0, rd);
    check_value("STATUS", status_word(0, 1'b1, 1'b0), rd.data);
    read_reg(`RNG_ADDR_DATA, 0, rd); // empty pop
    check_value("DATA", 32'd0, rd.data);
    check_value("DATA resp", 32'(AXIL_SLVERR), 32'(rd.resp));
    check_seed_regs(rng_seed_t'{`RNG_DEFAULT_SEED0, `RNG_DEFAULT_SEED1,
                                `RNG_DEFAULT_SEED2, `RNG_DEFAULT_SEED3});

    test_name = "sequence";
    load_seed(random_seed());
    pop_and_check(40);

    test_name = "backpressure";
    polls = 0;
    do begin
      read_reg(`RNG_ADDR_STATUS, 0, rd);
      polls++;
    end while (!rd.data[0] && polls < POLL_LIMIT);
    check_value("STATUS full", status_word(`RNG_FIFO_DEPTH, 1'b0, 1'b1), rd.data);
    read_reg(`RNG_ADDR_DATA, 6, rd); // stall R for 6 cycles
    model_step(model, skip);
    check_value("stalled DATA word", skip, rd.data);
    pop_and_check(2 * `RNG_FIFO_DEPTH); // producer refills behind the reads

    test_name = "reseed";
    load_seed(random_seed()); // old words are still queued here
    pop_and_check(24);

    test_name = "state readback";
    write_reg(`RNG_ADDR_CTRL, 32'h0, resp);
    read_reg(`RNG_ADDR_STATUS, 0, rd);
    while (!rd.data[1]) begin
      pop_and_check(1);
      read_reg(`RNG_ADDR_STATUS, 0, rd);
    end
    ahead = model;
    model_step(ahead, skip); // one word still sits in the generator output register
    check_seed_regs(ahead);

    test_name = "errors";
    read_reg(32'h0000_0020, 0, rd);
    check_value("unmapped rresp", 32'(AXIL_SLVERR), 32'(rd.resp));
    write_reg(32'h0000_0024, 32'h1, resp);
    check_value("unmapped bresp", 32'(AXIL_SLVERR), 32'(resp));
    write_reg(`RNG_ADDR_STATUS, 32'hFFFF_FFFF, resp);
    check_value("STATUS bresp", 32'(AXIL_OKAY), 32'(resp));
    read_reg(`RNG_ADDR_STATUS, 0, rd);
    check_value("STATUS after write", status_word(0, 1'b1, 1'b0), rd.data);

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+source
+incdir+test
source/rng_pkg.sv
source/prng_xoshiro128pp.sv
source/sync_fifo.sv
source/axil_rng_regs.sv
source/rng_subsystem_top.sv
test/tb_rng_subsystem.sv

//--- Makefile
SIM := obj_dir/Vtb_rng_subsystem
SRCS := project.f $(wildcard source/*.sv source/*.svh test/*.sv test/*.svh)

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Test completed successfully" sim.log

$(SIM): $(SRCS)
	verilator --binary --assert --timing --timescale 1ns/1ns -Wno-fatal \
	  -f project.f --top-module tb_rng_subsystem --Mdir obj_dir

clean:
	rm -rf obj_dir sim.log
